//--- common/car_dodge_params.svh
`ifndef CAR_DODGE_PARAMS_SVH
`define CAR_DODGE_PARAMS_SVH

// 160x120 frame buffer
`define SCREEN_W        160
`define SCREEN_H        120

`define SPRITE_SIDE     4
`define SPRITE_PIXELS   (`SPRITE_SIDE * `SPRITE_SIDE)
`define X_MAX           (`SCREEN_W - `SPRITE_SIDE)  // rightmost origin column
`define Y_MAX           (`SCREEN_H - `SPRITE_SIDE)  // lowest player row

`define LANE_A_Y        40
`define LANE_B_Y        90
`define PLAYER_X        80
`define PLAYER_Y0       100

// ps/2 make codes
`define KEY_DOWN        8'h1B
`define KEY_UP          8'h1D

`define COLOUR_BLACK    0
`define COLOUR_BLUE     1
`define COLOUR_GREEN    2
`define COLOUR_RED      4

`define TICK_CYCLES     12500000  // 4 Hz frame rate at 50 MHz
`define NUM_SPRITES     3

`endif

//--- common/car_dodge_pkg.sv
`default_nettype none

package car_dodge_pkg;

    typedef logic [7:0] x_coord_t;      // column, 0..159
    typedef logic [6:0] y_coord_t;      // row, 0..119
    typedef logic [2:0] colour_t;       // {r, g, b}
    typedef logic [7:0] scan_code_t;

    // low bits give the column offset, high bits the row offset
    typedef logic [3:0] pixel_idx_t;

    typedef logic [23:0] tick_count_t;

    typedef enum logic [2:0] {
        st_start,
        st_draw,
        st_idle,
        st_erase,
        st_update
    } sprite_state_t;

endpackage

`default_nettype wire

//--- common/pixel_if.sv
`timescale 1ns/1ps
`default_nettype none

// one sprite's pixel write towards the arbiter
interface pixel_if;
    import car_dodge_pkg::*;

    logic       req;     // held until granted
    logic       grant;
    x_coord_t   x;
    y_coord_t   y;
    colour_t    colour;

    modport sprite (
        output req, x, y, colour,
        input  grant
    );

    modport arbiter (
        input  req, x, y, colour,
        output grant
    );

endinterface

`default_nettype wire

//--- common/sprite_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface sprite_ctrl_if;

    logic draw;        // level, emit the 16 pixels
    logic erase;       // level, only together with draw
    logic update;      // single-cycle move request
    logic pass_done;   // last pixel of a pass granted

    modport ctrl (
        output draw, erase, update,
        input  pass_done
    );

    modport datapath (
        input  draw, erase, update,
        output pass_done
    );

endinterface

`default_nettype wire

//--- compile.f
+incdir+common
common/car_dodge_pkg.sv
common/pixel_if.sv
common/sprite_ctrl_if.sv
sprite/sprite_ctrl.sv
sprite/sprite_bounce.sv
sprite/sprite_player.sv
rtl/pixel_arbiter.sv
rtl/car_dodge_top.sv
tb/tb_car_dodge.sv

//--- rtl/car_dodge_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "car_dodge_params.svh"

module car_dodge_top #(
    parameter int tick_cycles = `TICK_CYCLES
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  car_dodge_pkg::scan_code_t  scan_code,
    output logic                       plot,
    output car_dodge_pkg::x_coord_t    x,
    output car_dodge_pkg::y_coord_t    y,
    output car_dodge_pkg::colour_t     colour
);
    import car_dodge_pkg::*;

    // 0 lane a, 1 lane b, 2 player
    sprite_ctrl_if sc_if [`NUM_SPRITES] ();
    pixel_if       px_if [`NUM_SPRITES] ();

    for (genvar i = 0; i < `NUM_SPRITES; i++)
    begin : g_ctrl
        sprite_ctrl #(
            .tick_cycles (tick_cycles)
        ) u_ctrl (
            .clk    (clk),
            .resetn (resetn),
            .ctrl   (sc_if[i])
        );
    end

    sprite_bounce #(
        .lane_y        (y_coord_t'(`LANE_A_Y)),
        .start_x       (x_coord_t'(`X_MAX)),
        .start_right   (1'b0),
        .sprite_colour (colour_t'(`COLOUR_RED))
    ) lane_a (
        .clk    (clk),
        .resetn (resetn),
        .ctrl   (sc_if[0]),
        .pix    (px_if[0])
    );

    sprite_bounce #(
        .lane_y        (y_coord_t'(`LANE_B_Y)),
        .start_x       (x_coord_t'(0)),
        .start_right   (1'b1),
        .sprite_colour (colour_t'(`COLOUR_BLUE))
    ) lane_b (
        .clk    (clk),
        .resetn (resetn),
        .ctrl   (sc_if[1]),
        .pix    (px_if[1])
    );

    sprite_player #(
        .sprite_colour (colour_t'(`COLOUR_GREEN))
    ) player (
        .clk       (clk),
        .resetn    (resetn),
        .scan_code (scan_code),
        .ctrl      (sc_if[2]),
        .pix       (px_if[2])
    );

    pixel_arbiter u_arbiter (
        .clk    (clk),
        .resetn (resetn),
        .src    (px_if),
        .plot   (plot),
        .x      (x),
        .y      (y),
        .colour (colour)
    );

endmodule

`default_nettype wire

//--- rtl/pixel_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "car_dodge_params.svh"

module pixel_arbiter (
    input  logic                     clk,
    input  logic                     resetn,
    pixel_if.arbiter                 src [`NUM_SPRITES],
    output logic                     plot,
    output car_dodge_pkg::x_coord_t  x,
    output car_dodge_pkg::y_coord_t  y,
    output car_dodge_pkg::colour_t   colour
);
    import car_dodge_pkg::*;

    localparam int num   = `NUM_SPRITES;
    localparam int idx_w = $clog2(num);

    typedef logic [idx_w-1:0] src_idx_t;

    logic [num-1:0] req_vec;
    logic [num-1:0] grant_vec;
    x_coord_t       x_arr [num];
    y_coord_t       y_arr [num];
    colour_t        c_arr [num];
    src_idx_t       last_q;     // last granted source
    src_idx_t       sel;

    for (genvar i = 0; i < num; i++)
    begin : g_src
        assign req_vec[i]   = src[i].req;
        assign x_arr[i]     = src[i].x;
        assign y_arr[i]     = src[i].y;
        assign c_arr[i]     = src[i].colour;
        assign src[i].grant = grant_vec[i];
    end

    // search starts just after the last winner
    always_comb
    begin
        logic     found;
        src_idx_t cand;
        grant_vec = '0;
        sel       = last_q;
        found     = 1'b0;
        for (int k = 1; k <= num; k++)
        begin
            cand = src_idx_t'((int'(last_q) + k) % num);
            if (!found && req_vec[cand])
            begin
                grant_vec[cand] = 1'b1;
                sel             = cand;
                found           = 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            plot   <= 1'b0;
            last_q <= src_idx_t'(num - 1);   // source 0 wins first
        end
        else
        begin
            plot <= |grant_vec;
            if (|grant_vec)
                last_q <= sel;
        end
    end

    always_ff @(posedge clk)
    begin
        if (|grant_vec)
        begin
            x      <= x_arr[sel];
            y      <= y_arr[sel];
            colour <= c_arr[sel];
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(grant_vec));
    a_grant_to_req: assert property (@(posedge clk) disable iff (!resetn)
        (grant_vec & ~req_vec) == '0);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# builds the testbench with verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_car_dodge -f compile.f \
    -o sim_car_dodge > build.log 2>&1 \
    && ./obj_dir/sim_car_dodge > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

cat sim.log
grep -q "Simulation FAILED" sim.log \
    && { echo "run_sim: failure reported in sim.log"; exit 1; } \
    || echo "run_sim: no failure in sim.log"

//--- sprite/sprite_bounce.sv
`timescale 1ns/1ps
`default_nettype none

`include "car_dodge_params.svh"

module sprite_bounce #(
    parameter car_dodge_pkg::y_coord_t lane_y        = 7'(`LANE_A_Y),
    parameter car_dodge_pkg::x_coord_t start_x       = 8'(`X_MAX),
    parameter bit                      start_right   = 1'b0,
    parameter car_dodge_pkg::colour_t  sprite_colour = 3'(`COLOUR_RED)
) (
    input  logic              clk,
    input  logic              resetn,
    sprite_ctrl_if.datapath   ctrl,
    pixel_if.sprite           pix
);
    import car_dodge_pkg::*;

    x_coord_t   origin_x;
    logic       dir_right;     // 1 = moving right
    logic       move_right;
    pixel_idx_t idx;
    logic       fire;

    assign fire = pix.req && pix.grant;

    // index only advances on a granted pixel
    always_ff @(posedge clk)
    begin
        if (!resetn)
            idx <= '0;
        else if (fire)
            idx <= idx + 1'b1;   // wraps to 0 after the 16th
    end

    assign ctrl.pass_done = fire && (idx == pixel_idx_t'(`SPRITE_PIXELS - 1));

    // bounce off either edge
    always_comb
    begin
        if (origin_x == '0)
            move_right = 1'b1;
        else if (origin_x == x_coord_t'(`X_MAX))
            move_right = 1'b0;
        else
            move_right = dir_right;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            origin_x  <= start_x;
            dir_right <= start_right;
        end
        else if (ctrl.update)
        begin
            dir_right <= move_right;
            origin_x  <= move_right ? origin_x + 1'b1 : origin_x - 1'b1;
        end
    end

    assign pix.req    = ctrl.draw;
    assign pix.x      = origin_x + x_coord_t'(idx[1:0]);
    assign pix.y      = lane_y + y_coord_t'(idx[3:2]);
    assign pix.colour = ctrl.erase ? colour_t'(`COLOUR_BLACK) : sprite_colour;

    a_origin_in_range: assert property (@(posedge clk) disable iff (!resetn)
        origin_x <= x_coord_t'(`X_MAX));

endmodule

`default_nettype wire

//--- sprite/sprite_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "car_dodge_params.svh"

module sprite_ctrl #(
    parameter int tick_cycles = `TICK_CYCLES
) (
    input  logic              clk,
    input  logic              resetn,
    sprite_ctrl_if.ctrl       ctrl
);
    import car_dodge_pkg::*;

    sprite_state_t state_q;
    sprite_state_t state_d;
    tick_count_t   tick_cnt;
    logic          tick_wrap;

    // free running frame timer
    assign tick_wrap = (tick_cnt == tick_count_t'(tick_cycles - 1));

    always_ff @(posedge clk)
    begin
        if (!resetn)
            tick_cnt <= '0;
        else if (tick_wrap)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            st_start:  state_d = st_draw;
            st_draw:
                if (ctrl.pass_done)
                    state_d = st_idle;
            st_idle:
                if (tick_wrap)
                    state_d = st_erase;   // next frame
            st_erase:
                if (ctrl.pass_done)
                    state_d = st_update;
            st_update: state_d = st_draw;
            default:   state_d = st_start;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
            state_q <= st_start;
        else
            state_q <= state_d;
    end

    // outputs decoded straight from the state
    assign ctrl.draw   = (state_q == st_draw) || (state_q == st_erase);
    assign ctrl.erase  = (state_q == st_erase);
    assign ctrl.update = (state_q == st_update);

    // pass_done from the datapath only inside a pass, one cycle wide
    a_done_in_pass: assert property (@(posedge clk) disable iff (!resetn)
        ctrl.pass_done |-> ctrl.draw);
    a_done_one_cycle: assert property (@(posedge clk) disable iff (!resetn)
        ctrl.pass_done |=> !ctrl.pass_done);

endmodule

`default_nettype wire

//--- sprite/sprite_player.sv
`timescale 1ns/1ps
`default_nettype none

`include "car_dodge_params.svh"

module sprite_player #(
    parameter car_dodge_pkg::colour_t sprite_colour = 3'(`COLOUR_GREEN)
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  car_dodge_pkg::scan_code_t  scan_code,
    sprite_ctrl_if.datapath            ctrl,
    pixel_if.sprite                    pix
);
    import car_dodge_pkg::*;

    y_coord_t   row;
    pixel_idx_t idx;
    logic       fire;
    logic       at_top;
    logic       at_bottom;

    assign fire      = pix.req && pix.grant;
    assign at_top    = (row == '0);
    assign at_bottom = (row == y_coord_t'(`Y_MAX));

    always_ff @(posedge clk)
    begin
        if (!resetn)
            idx <= '0;
        else if (fire)
            idx <= idx + 1'b1;
    end

    assign ctrl.pass_done = fire && (idx == pixel_idx_t'(`SPRITE_PIXELS - 1));

    // one row per frame, held inside the screen
    always_ff @(posedge clk)
    begin
        if (!resetn)
            row <= y_coord_t'(`PLAYER_Y0);
        else if (ctrl.update)
        begin
            if (scan_code == `KEY_DOWN && !at_bottom)
                row <= row + 1'b1;
            else if (scan_code == `KEY_UP && !at_top)
                row <= row - 1'b1;
        end
    end

    assign pix.req    = ctrl.draw;
    assign pix.x      = x_coord_t'(`PLAYER_X) + x_coord_t'(idx[1:0]);
    assign pix.y      = row + y_coord_t'(idx[3:2]);
    assign pix.colour = ctrl.erase ? colour_t'(`COLOUR_BLACK) : sprite_colour;

endmodule

`default_nettype wire

//--- tb/tb_car_dodge.sv
`timescale 1ns/1ps
`default_nettype none

`include "car_dodge_params.svh"

module tb_car_dodge;
    import car_dodge_pkg::*;

    typedef struct packed {
        x_coord_t x;
        y_coord_t y;
        colour_t  c;
    } pix_t;

    logic       clk;
    logic       resetn;
    scan_code_t scan_code;
    logic       plot;
    x_coord_t   x;
    y_coord_t   y;
    colour_t    colour;

    int         seed;
    int         errors;
    int         tests;
    int         failed;
    bit         timed_out;
    pix_t       exp_q [`NUM_SPRITES][$];   // erase entries first, then draw
    int         erase_left [`NUM_SPRITES];
    x_coord_t   model_x [`NUM_SPRITES];
    y_coord_t   model_y [`NUM_SPRITES];
    logic       lane_right [2];
    x_coord_t   seen_x [`NUM_SPRITES];     // top left corner of the drawn sprite
    y_coord_t   seen_y [`NUM_SPRITES];

    car_dodge_top #(
        .tick_cycles (200)
    ) DUT (
        .clk       (clk),
        .resetn    (resetn),
        .scan_code (scan_code),
        .plot      (plot),
        .x         (x),
        .y         (y),
        .colour    (colour)
    );

    always #10 clk = ~clk;

    function automatic colour_t sprite_colour(input int s);
        if (s == 0)
            return colour_t'(`COLOUR_RED);
        if (s == 1)
            return colour_t'(`COLOUR_BLUE);
        return colour_t'(`COLOUR_GREEN);
    endfunction

    function automatic string sprite_name(input int s);
        if (s == 0)
            return "lane_a";
        if (s == 1)
            return "lane_b";
        return "player";
    endfunction

    // pixel k of a 4x4 sprite, row by row
    function automatic pix_t sprite_pixel(input x_coord_t x0, input y_coord_t y0,
                                          input colour_t c, input int k);
        pix_t p;
        p.x = x0 + x_coord_t'(k % `SPRITE_SIDE);
        p.y = y0 + y_coord_t'(k / `SPRITE_SIDE);
        p.c = c;
        return p;
    endfunction

    // direction for the next step of a lane block
    function automatic logic bounce_dir(input x_coord_t px, input logic right);
        if (px == 0)
            return 1'b1;
        if (px == x_coord_t'(`X_MAX))
            return 1'b0;
        return right;
    endfunction

    function automatic y_coord_t player_row(input y_coord_t row, input scan_code_t code);
        if (code == `KEY_DOWN && row < y_coord_t'(`Y_MAX))
            return row + 7'd1;
        if (code == `KEY_UP && row > 0)
            return row - 7'd1;
        return row;   // other keys, or at the edge
    endfunction

    function automatic bit pending();
        for (int s = 0; s < `NUM_SPRITES; s++)
            if (exp_q[s].size() > 0)
                return 1'b1;
        return 1'b0;
    endfunction

    task automatic check_x(input string name, input x_coord_t got, input x_coord_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_y(input string name, input y_coord_t got, input y_coord_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_colour(input string name, input colour_t got, input colour_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic expect_pass(input int s, input logic erase);
        colour_t c;
        c = erase ? colour_t'(`COLOUR_BLACK) : sprite_colour(s);
        for (int k = 0; k < `SPRITE_PIXELS; k++)
            exp_q[s].push_back(sprite_pixel(model_x[s], model_y[s], c, k));
        if (erase)
            erase_left[s] = `SPRITE_PIXELS;
    endtask

    // while a sprite still owes erase pixels only those may match
    task automatic match_write(input pix_t w);
        int hit_s;
        int hit_i;
        int lim;
        hit_s = -1;
        hit_i = -1;
        for (int s = 0; s < `NUM_SPRITES; s++)
        begin
            lim = (erase_left[s] > 0) ? erase_left[s] : exp_q[s].size();
            for (int i = 0; i < lim; i++)
                if (hit_s < 0 && exp_q[s][i].x == w.x && exp_q[s][i].y == w.y)
                begin
                    hit_s = s;
                    hit_i = i;
                end
        end
        if (hit_s < 0)
        begin
            errors++;
            $display("unexpected write at column %0d row %0d in colour %0d", w.x, w.y, w.c);
        end
        else
        begin
            check_colour("colour", w.c, exp_q[hit_s][hit_i].c);
            exp_q[hit_s].delete(hit_i);
            if (erase_left[hit_s] > 0)
                erase_left[hit_s]--;
        end
    endtask

    always @(negedge clk)
    begin
        if (!resetn)
        begin
            if (plot !== 1'b0)
            begin
                errors++;
                $display("plot is not low during reset");
            end
        end
        else if (plot === 1'b1)
        begin
            match_write(pix_t'({x, y, colour}));
            for (int s = 0; s < `NUM_SPRITES; s++)
                if (colour == sprite_colour(s))
                begin
                    if (x < seen_x[s])
                        seen_x[s] = x;
                    if (y < seen_y[s])
                        seen_y[s] = y;
                end
        end
        else if (plot !== 1'b0)
        begin
            errors++;
            $display("plot is unknown after reset");
        end
    end

    task automatic draw_frame(input string what);
        int cycles;
        for (int s = 0; s < `NUM_SPRITES; s++)
        begin
            expect_pass(s, 1'b0);
            seen_x[s] = 8'hff;
            seen_y[s] = 7'h7f;
        end
        cycles = 0;
        while (pending() && cycles < 600)   // 3 frame periods
        begin
            @(posedge clk);
            #2;
            cycles++;
        end
        if (pending())
        begin
            timed_out = 1'b1;
            $display("timeout, %s did not write all expected pixels", what);
        end
        else
            for (int s = 0; s < `NUM_SPRITES; s++)
            begin
                check_x({sprite_name(s), ".x"}, seen_x[s], model_x[s]);
                check_y({sprite_name(s), ".y"}, seen_y[s], model_y[s]);
            end
    endtask

    task automatic run_frame(input scan_code_t code, input string what);
        scan_code = code;   // stable well before the update
        for (int s = 0; s < `NUM_SPRITES; s++)
            expect_pass(s, 1'b1);
        for (int s = 0; s < 2; s++)
        begin
            lane_right[s] = bounce_dir(model_x[s], lane_right[s]);
            model_x[s] = lane_right[s] ? model_x[s] + 8'd1 : model_x[s] - 8'd1;
        end
        model_y[2] = player_row(model_y[2], code);
        draw_frame(what);
    endtask

    task automatic report(input string name, input int err0);
        tests++;
        if (errors == err0 && !timed_out)
            $display("PASS: %s", name);
        else
        begin
            failed++;
            $display("FAIL: %s, %0d errors", name, errors - err0);
        end
    endtask

    // mode 0 random keys, 1 down, 2 up
    task automatic run_phase(input string name, input int frames, input int mode);
        int         err0;
        int         pick;
        scan_code_t code;
        err0 = errors;
        for (int f = 0; f < frames && !timed_out; f++)
        begin
            pick = $random(seed);
            pick = ((pick % 3) + 3) % 3;
            if (mode == 1 || (mode == 0 && pick == 0))
                code = `KEY_DOWN;
            else if (mode == 2 || (mode == 0 && pick == 1))
                code = `KEY_UP;
            else
                code = 8'h29;
            run_frame(code, name);
        end
        report(name, err0);
    endtask

    initial
    begin
        int err0;
        clk       = 1'b0;
        resetn    = 1'b0;
        scan_code = 8'h00;
        seed      = 27;
        errors    = 0;
        tests     = 0;
        failed    = 0;
        timed_out = 1'b0;
        model_x[0] = x_coord_t'(`X_MAX);
        model_y[0] = y_coord_t'(`LANE_A_Y);
        model_x[1] = 8'd0;
        model_y[1] = y_coord_t'(`LANE_B_Y);
        model_x[2] = x_coord_t'(`PLAYER_X);
        model_y[2] = y_coord_t'(`PLAYER_Y0);
        lane_right[0] = 1'b0;
        lane_right[1] = 1'b1;
        for (int s = 0; s < `NUM_SPRITES; s++)
            erase_left[s] = 0;
        repeat (3) @(posedge clk);
        #2;
        resetn = 1'b1;
        err0 = errors;
        draw_frame("first frame");
        report("reset and first frame", err0);
        run_phase("random keys", 8, 0);
        run_phase("player down to Y_MAX", 28, 1);
        run_phase("player up to 0", 120, 2);   // lane_b hits X_MAX at the end
        run_phase("lanes reverse at the edges", 4, 0);
        repeat (20) @(posedge clk);   // catch stray writes
        $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
        if (timed_out || failed > 0 || errors > 0)
            $display("Simulation FAILED");
        else
            $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire
